/* Bender.yml */
package:
  name: r2f

sources:
  - files:
      - src/r2f_pkg.sv
      - src/bank_ram.sv
      - src/bank_fill.sv
      - src/bank_gather.sv
      - src/byte_fifo.sv
      - src/fifo_drain.sv
      - src/r2f_seq.sv
      - src/r2f_top.sv
  - target: test
    files:
      - verif/r2f_checker.sv
      - verif/r2f_props.sv
      - verif/tb_r2f.sv

/* src/bank_fill.sv */
`timescale 1ns/1ps

module bank_fill (
    input  logic                                        clk_50,
    input  logic                                        rst,
    input  logic                                        fill_start,
    input  r2f_pkg::run_cfg_t                           cfg_q,
    output r2f_pkg::lane_wr_t [r2f_pkg::LANES-1:0]      lane_wr,
    output logic                                        fill_done
);
    import r2f_pkg::*;

    logic              active;
    logic [ADDR_W-1:0] addr_q;
    logic [LEN_W-1:0]  left;

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            addr_q    <= '0;
            left      <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (fill_start) begin
                active <= 1'b1;
                addr_q <= cfg_q.base;
                left   <= cfg_q.len;
            end else if (active) begin
                // Address wraps at the top of the lane
                addr_q <= addr_q + 1'b1;
                left   <= left - 1'b1;
                if (left == LEN_W'(1)) begin
                    active    <= 1'b0;
                    fill_done <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_wr[k].addr = addr_q;
            lane_wr[k].data = addr_q[7:0] + lane_bias(k);
            lane_wr[k].en   = active;
        end
    end

endmodule

/* src/bank_gather.sv */
`timescale 1ns/1ps

module bank_gather (
    input  logic                               clk_50,
    input  logic                               rst,
    input  logic                               gather_start,
    input  r2f_pkg::run_cfg_t                  cfg_q,
    input  logic [r2f_pkg::LANES*8-1:0]        rd_data,
    input  logic                               full,
    output logic [r2f_pkg::ADDR_W-1:0]         rd_addr,
    output logic                               push,
    output logic [7:0]                         push_data,
    output logic                               gather_done
);
    import r2f_pkg::*;

    logic              run;
    logic              ready;
    logic [LEN_W-1:0]  fetch_left;
    logic [LANES*8-1:0] word_q;
    logic [LANES-1:0]  pend;
    logic [LANES-1:0]  pend_after;
    logic [LANES-1:0]  lane_bit;
    logic [LANE_W-1:0] cur_lane;
    logic              load;
    logic              last;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane walk, highest enabled lane first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        cur_lane = '0;
        for (int k = 0; k < LANES; k++) begin
            if (pend[k]) begin
                cur_lane = LANE_W'(k);
            end
        end
        lane_bit           = '0;
        lane_bit[cur_lane] = 1'b1;
    end

    assign push       = run && (pend != '0) && !full;
    assign push_data  = word_q[cur_lane*8 +: 8];
    assign pend_after = push ? (pend & ~lane_bit) : pend;

    // The next word is taken once the current one is fully sent
    assign load = run && ready && (fetch_left != '0) && (pend_after == '0);
    assign last = run && (fetch_left == '0) && (pend_after == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch and buffer control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            run         <= 1'b0;
            ready       <= 1'b0;
            fetch_left  <= '0;
            rd_addr     <= '0;
            pend        <= '0;
            gather_done <= 1'b0;
        end else begin
            gather_done <= 1'b0;
            if (gather_start) begin
                run        <= 1'b1;
                ready      <= 1'b0;
                fetch_left <= cfg_q.len;
                rd_addr    <= cfg_q.base;
                pend       <= '0;
            end else if (run) begin
                if (load) begin
                    // rd_data shows the new address two edges from now
                    ready      <= 1'b0;
                    fetch_left <= fetch_left - 1'b1;
                    rd_addr    <= rd_addr + 1'b1;
                    pend       <= cfg_q.link;
                end else begin
                    ready <= 1'b1;
                    pend  <= pend_after;
                end
                if (last) begin
                    run         <= 1'b0;
                    gather_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (load) begin
            word_q <= rd_data;
        end
    end

endmodule

/* src/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram (
    input  logic                          clk_50,
    input  r2f_pkg::lane_wr_t             wr,
    input  logic [r2f_pkg::ADDR_W-1:0]    rd_addr,
    output logic [7:0]                    rd_data
);
    import r2f_pkg::*;

    logic [7:0] mem [1 << ADDR_W];

    always_ff @(posedge clk_50) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read, data follows the address by one cycle
    always_ff @(posedge clk_50) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* src/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo (
    input  logic       clk_50,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);
    import r2f_pkg::*;

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               wr_ok;
    logic               rd_ok;

    assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign wr_ok = push && !full;
    assign rd_ok = pop && !empty;

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the level unchanged
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (wr_ok) begin
            mem[wr_ptr] <= push_data;
        end
        if (rd_ok) begin
            pop_data <= mem[rd_ptr];
        end
    end

endmodule

/* src/fifo_drain.sv */
`timescale 1ns/1ps

module fifo_drain (
    input  logic                        clk_50,
    input  logic                        rst,
    input  logic                        drain_start,
    input  logic [r2f_pkg::CNT_W-1:0]   drain_count,
    input  logic                        empty,
    input  logic [7:0]                  pop_data,
    output logic                        pop,
    output logic [7:0]                  out_byte,
    output logic                        out_valid,
    output logic                        drain_done
);
    import r2f_pkg::*;

    logic             active;
    logic [CNT_W-1:0] remaining;

    assign pop      = active && (remaining != '0) && !empty;
    assign out_byte = pop_data;

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            active     <= 1'b0;
            remaining  <= '0;
            out_valid  <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            out_valid  <= pop;
            drain_done <= 1'b0;
            if (drain_start) begin
                remaining <= drain_count;
                if (drain_count == '0) begin
                    drain_done <= 1'b1;
                end else begin
                    active <= 1'b1;
                end
            end else if (active) begin
                if (pop) begin
                    remaining <= remaining - 1'b1;
                end
                // Last byte is on the port this cycle
                if (out_valid && remaining == '0) begin
                    active     <= 1'b0;
                    drain_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/r2f_pkg.sv */
package r2f_pkg;

    localparam int LANES      = 8;
    localparam int LANE_W     = $clog2(LANES);
    localparam int ADDR_W     = 12;
    localparam int LEN_W      = 8;
    localparam int CNT_W      = 11;
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    // Run settings captured on start
    typedef struct packed {
        logic [ADDR_W-1:0] base;
        logic [LEN_W-1:0]  len;
        logic [LANES-1:0]  link;
    } run_cfg_t;

    // One write into a lane memory
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;
        logic              en;
    } lane_wr_t;

    // Lane k adds 2k+1 to the low address byte
    function automatic logic [7:0] lane_bias(input int unsigned lane);
        logic [7:0] bias;
        bias = 8'(2 * lane + 1);
        return bias;
    endfunction

endpackage

/* src/r2f_seq.sv */
`timescale 1ns/1ps

module r2f_seq (
    input  logic                        clk_50,
    input  logic                        rst,
    input  logic                        start,
    input  r2f_pkg::run_cfg_t           cfg,
    input  logic                        fill_done,
    input  logic                        gather_done,
    input  logic                        drain_done,
    output r2f_pkg::run_cfg_t           cfg_q,
    output logic                        fill_start,
    output logic                        gather_start,
    output logic                        drain_start,
    output logic [r2f_pkg::CNT_W-1:0]   drain_count,
    output logic                        busy,
    output logic                        done
);
    import r2f_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_MOVE,
        ST_FINISH
    } state_t;

    state_t          state;
    logic            gather_seen;
    logic [LANE_W:0] lane_cnt;
    logic            gather_ok;

    always_comb begin
        lane_cnt = '0;
        for (int k = 0; k < LANES; k++) begin
            lane_cnt = lane_cnt + (LANE_W+1)'(cfg.link[k]);
        end
    end

    assign gather_ok = gather_seen || gather_done;
    assign busy      = (state != ST_IDLE);

    // Done lines up with drain_done so it trails the last byte by one cycle
    assign done = ((state == ST_MOVE) && drain_done && gather_ok) ||
                  ((state == ST_FINISH) && gather_done);

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            gather_seen  <= 1'b0;
            fill_start   <= 1'b0;
            gather_start <= 1'b0;
            drain_start  <= 1'b0;
        end else begin
            fill_start   <= 1'b0;
            gather_start <= 1'b0;
            drain_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        fill_start <= 1'b1;
                        state      <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (fill_done) begin
                        gather_start <= 1'b1;
                        drain_start  <= 1'b1;
                        gather_seen  <= 1'b0;
                        state        <= ST_MOVE;
                    end
                end
                ST_MOVE: begin
                    if (gather_done) begin
                        gather_seen <= 1'b1;
                    end
                    // An empty mask lets drain finish before gather
                    if (drain_done) begin
                        state <= gather_ok ? ST_IDLE : ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    if (gather_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_50) begin
        if (start && state == ST_IDLE) begin
            cfg_q       <= cfg;
            drain_count <= CNT_W'(cfg.len) * CNT_W'(lane_cnt);
        end
    end

endmodule

/* src/r2f_top.sv */
`timescale 1ns/1ps

module r2f_top (
    input  logic              clk_50,
    input  logic              rst,
    input  logic              start,
    input  r2f_pkg::run_cfg_t cfg,
    output logic [7:0]        out_byte,
    output logic              out_valid,
    output logic              busy,
    output logic              done
);
    import r2f_pkg::*;

    run_cfg_t                cfg_q;
    logic                    fill_start;
    logic                    fill_done;
    logic                    gather_start;
    logic                    gather_done;
    logic                    drain_start;
    logic                    drain_done;
    logic [CNT_W-1:0]        drain_count;
    lane_wr_t [LANES-1:0]    lane_wr;
    logic [ADDR_W-1:0]       rd_addr;
    logic [LANES*8-1:0]      rd_data;
    logic                    push;
    logic [7:0]              push_data;
    logic                    pop;
    logic [7:0]              pop_data;
    logic                    full;
    logic                    empty;

    r2f_seq u_seq (
        .clk_50       (clk_50),
        .rst          (rst),
        .start        (start),
        .cfg          (cfg),
        .fill_done    (fill_done),
        .gather_done  (gather_done),
        .drain_done   (drain_done),
        .cfg_q        (cfg_q),
        .fill_start   (fill_start),
        .gather_start (gather_start),
        .drain_start  (drain_start),
        .drain_count  (drain_count),
        .busy         (busy),
        .done         (done)
    );

    bank_fill u_fill (
        .clk_50     (clk_50),
        .rst        (rst),
        .fill_start (fill_start),
        .cfg_q      (cfg_q),
        .lane_wr    (lane_wr),
        .fill_done  (fill_done)
    );

    // Lane k drives byte k of the read word
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        bank_ram u_ram (
            .clk_50  (clk_50),
            .wr      (lane_wr[k]),
            .rd_addr (rd_addr),
            .rd_data (rd_data[8*k +: 8])
        );
    end

    bank_gather u_gather (
        .clk_50       (clk_50),
        .rst          (rst),
        .gather_start (gather_start),
        .cfg_q        (cfg_q),
        .rd_data      (rd_data),
        .full         (full),
        .rd_addr      (rd_addr),
        .push         (push),
        .push_data    (push_data),
        .gather_done  (gather_done)
    );

    byte_fifo u_fifo (
        .clk_50    (clk_50),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    fifo_drain u_drain (
        .clk_50      (clk_50),
        .rst         (rst),
        .drain_start (drain_start),
        .drain_count (drain_count),
        .empty       (empty),
        .pop_data    (pop_data),
        .pop         (pop),
        .out_byte    (out_byte),
        .out_valid   (out_valid),
        .drain_done  (drain_done)
    );

endmodule

/* verif/r2f_checker.sv */
`timescale 1ns/1ps

module r2f_checker (
    input  logic                      clk_50,
    input  logic                      rst,
    input  logic                      test_load,
    input  r2f_pkg::run_cfg_t         test_cfg,
    input  logic [r2f_pkg::CNT_W-1:0] exp_count,
    input  logic [7:0]                exp_xor,
    input  logic [7:0]                out_byte,
    input  logic                      out_valid,
    input  logic                      done,
    output int                        tests_run,
    output int                        tests_failed,
    output int                        byte_errors,
    output int                        stray_events
);
    import r2f_pkg::*;

    run_cfg_t          cfg_l;
    logic [CNT_W-1:0]  count_l;
    logic [7:0]        xor_l;
    logic              armed;
    logic [ADDR_W-1:0] addr;
    int                lane;
    int                total;
    int                seen;
    int                wrong;
    logic [7:0]        xor_acc;
    logic              valid_d;

    function automatic int enabled_lanes(input logic [LANES-1:0] mask);
        int n;
        n = 0;
        for (int k = 0; k < LANES; k++) begin
            n += int'(mask[k]);
        end
        return n;
    endfunction

    // Highest enabled lane below the given one, or -1 when there is none
    function automatic int next_lane(input logic [LANES-1:0] mask, input int below);
        int found;
        found = -1;
        for (int k = 0; k < below; k++) begin
            if (mask[k]) begin
                found = k;
            end
        end
        return found;
    endfunction

    task automatic arm_test();
        if (armed) begin
            $display("A new test was loaded at %0t before the previous run finished", $time);
            stray_events++;
        end
        cfg_l   = test_cfg;
        count_l = exp_count;
        xor_l   = exp_xor;
        addr    = test_cfg.base;
        total   = int'(test_cfg.len) * enabled_lanes(test_cfg.link);
        lane    = next_lane(test_cfg.link, LANES);
        seen    = 0;
        wrong   = 0;
        xor_acc = '0;
        armed   = 1'b1;
    endtask

    task automatic check_byte();
        logic [7:0] want;
        if (!armed) begin
            $display("Output byte %02h arrived at %0t with no run in progress", out_byte, $time);
            stray_events++;
        end else if (lane < 0) begin
            $display("FAILED at %0t: extra byte %02h beyond the expected %0d",
                     $time, out_byte, total);
            byte_errors++;
            wrong++;
            seen++;
            xor_acc ^= out_byte;
        end else begin
            want = addr[7:0] + lane_bias(lane);
            if (out_byte !== want) begin
                $display("FAILED at %0t: byte %0d from addr %03h lane %0d is %02h, expected %02h",
                         $time, seen, addr, lane, out_byte, want);
                byte_errors++;
                wrong++;
            end
            seen++;
            xor_acc ^= out_byte;
            lane = next_lane(cfg_l.link, lane);
            if (lane < 0 && seen < total) begin
                addr = addr + 1'b1;
                lane = next_lane(cfg_l.link, LANES);
            end
        end
    endtask

    task automatic close_test();
        logic ok;
        ok = (wrong == 0);
        if (!armed) begin
            $display("Unexpected done pulse at %0t with no run in progress", $time);
            stray_events++;
        end else begin
            if (total != int'(count_l)) begin
                $display("FAILED at %0t: file count %0d differs from len times lanes %0d",
                         $time, count_l, total);
                ok = 1'b0;
            end
            if (seen != int'(count_l)) begin
                $display("FAILED at %0t: %0d bytes seen, expected %0d", $time, seen, count_l);
                ok = 1'b0;
            end
            if (xor_acc != xor_l) begin
                $display("FAILED at %0t: stream xor %02h, expected %02h", $time, xor_acc, xor_l);
                ok = 1'b0;
            end
            if (total > 0 && (!valid_d || out_valid)) begin
                $display("FAILED at %0t: done did not follow the last out_valid by one cycle",
                         $time);
                ok = 1'b0;
            end
            tests_run++;
            if (!ok) begin
                tests_failed++;
            end
            $display("Test %0d base %03h len %0d mask %02h: %0d bytes, xor %02h, %s",
                     tests_run, cfg_l.base, cfg_l.len, cfg_l.link, seen, xor_acc,
                     ok ? "ok" : "failed");
            armed = 1'b0;
        end
    endtask

    always @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            armed        = 1'b0;
            valid_d      = 1'b0;
            tests_run    = 0;
            tests_failed = 0;
            byte_errors  = 0;
            stray_events = 0;
        end else begin
            if (test_load) begin
                arm_test();
            end
            if (out_valid) begin
                check_byte();
            end
            if (done) begin
                close_test();
            end
            valid_d = out_valid;
        end
    end

endmodule

/* verif/r2f_props.sv */
`timescale 1ns/1ps

module r2f_props (
    input logic clk_50,
    input logic rst,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic out_valid,
    input logic busy,
    input logic done
);

    // FIFO side rules
    no_push_when_full: assert property (@(posedge clk_50) disable iff (rst) !(push && full))
        else $error("push seen while the FIFO is full");

    no_pop_when_empty: assert property (@(posedge clk_50) disable iff (rst) !(pop && empty))
        else $error("pop seen while the FIFO is empty");

    // Output port rules
    valid_needs_busy: assert property (@(posedge clk_50) disable iff (rst) out_valid |-> busy)
        else $error("out_valid seen while busy is low");

    done_one_cycle: assert property (@(posedge clk_50) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

endmodule

// The top level carries the FIFO nets, so one binding covers every rule
bind r2f_top r2f_props u_props (
    .clk_50    (clk_50),
    .rst       (rst),
    .push      (push),
    .full      (full),
    .pop       (pop),
    .empty     (empty),
    .out_valid (out_valid),
    .busy      (busy),
    .done      (done)
);

/* verif/r2f_tests.txt */
// Columns in hex: base len mask expected_count expected_xor
// A line with a length of 00 ends the list
010 04 FF 020 00
123 03 55 00C 10
200 03 80 003 0E
0A0 02 81 004 1C
7F0 02 3C 008 08
400 04 01 004 04
300 C8 FF 640 00
FFC 06 0F 018 08
E80 FF 02 0FF 82
050 06 00 000 00
000 00 00 000 00

/* verif/tb_r2f.sv */
`timescale 1ns/1ps

module tb_r2f;
    import r2f_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 3;
    localparam int DRIVE_DELAY = 1;
    localparam int SEED        = 36;
    localparam int MAX_TESTS   = 32;
    localparam int WD_MARGIN   = 20;

    logic             clk_50;
    logic             rst;
    logic             start;
    run_cfg_t         cfg;
    logic [7:0]       out_byte;
    logic             out_valid;
    logic             busy;
    logic             done;

    logic             test_load;
    logic [CNT_W-1:0] exp_count;
    logic [7:0]       exp_xor;
    int               tests_run;
    int               tests_failed;
    int               byte_errors;
    int               stray_events;

    // Five words per test, in the column order of the data file
    logic [15:0]      test_mem [5*MAX_TESTS];
    int               n_tests;
    int               tb_errors;
    int               wd_cycles;
    logic             wd_armed;

    r2f_top u_r2f_top (
        .clk_50    (clk_50),
        .rst       (rst),
        .start     (start),
        .cfg       (cfg),
        .out_byte  (out_byte),
        .out_valid (out_valid),
        .busy      (busy),
        .done      (done)
    );

    r2f_checker u_checker (
        .clk_50       (clk_50),
        .rst          (rst),
        .test_load    (test_load),
        .test_cfg     (cfg),
        .exp_count    (exp_count),
        .exp_xor      (exp_xor),
        .out_byte     (out_byte),
        .out_valid    (out_valid),
        .done         (done),
        .tests_run    (tests_run),
        .tests_failed (tests_failed),
        .byte_errors  (byte_errors),
        .stray_events (stray_events)
    );

    initial begin
        clk_50 = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_50 = ~clk_50;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test list and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_tests();
        for (int i = 0; i < 5*MAX_TESTS; i++) begin
            test_mem[i] = '0;
        end
        $readmemh("verif/r2f_tests.txt", test_mem);
        n_tests   = 0;
        wd_cycles = WD_MARGIN + RST_CYCLES;
        // A zero length ends the list
        while (n_tests < MAX_TESTS && test_mem[5*n_tests+1] != '0) begin
            wd_cycles += 10 * int'(test_mem[5*n_tests+3]) + int'(test_mem[5*n_tests+1]) + 50;
            n_tests++;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_50);
        #DRIVE_DELAY;
        rst = 1'b0;
    endtask

    task automatic wait_for_done();
        @(posedge clk_50);
        while (!done) begin
            @(posedge clk_50);
        end
    endtask

    task automatic run_test(input int idx);
        run_cfg_t c;
        c.base = test_mem[5*idx][ADDR_W-1:0];
        c.len  = test_mem[5*idx+1][LEN_W-1:0];
        c.link = test_mem[5*idx+2][LANES-1:0];
        @(posedge clk_50);
        #DRIVE_DELAY;
        cfg       = c;
        start     = 1'b1;
        test_load = 1'b1;
        exp_count = test_mem[5*idx+3][CNT_W-1:0];
        exp_xor   = test_mem[5*idx+4][7:0];
        @(posedge clk_50);
        #DRIVE_DELAY;
        start     = 1'b0;
        test_load = 1'b0;
        @(posedge clk_50);
        #DRIVE_DELAY;
        // The DUT is still filling here, so this start must change nothing
        if (busy) begin
            cfg   = run_cfg_t'(~c);
            start = 1'b1;
            @(posedge clk_50);
            #DRIVE_DELAY;
            start = 1'b0;
        end else begin
            $display("DUT did not raise busy after the start of test %0d", idx + 1);
            tb_errors++;
        end
        wait_for_done();
    endtask

    initial begin
        int gap;
        rst       = 1'b1;
        start     = 1'b0;
        cfg       = '0;
        test_load = 1'b0;
        exp_count = '0;
        exp_xor   = '0;
        tb_errors = 0;
        wd_armed  = 1'b0;
        void'($urandom(SEED));
        load_tests();
        if (n_tests == 0) begin
            $display("No tests were read from verif/r2f_tests.txt");
            tb_errors++;
        end
        wd_armed = 1'b1;
        apply_reset();
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
            gap = $urandom % 8;
            repeat (gap) @(posedge clk_50);
        end
        repeat (4) @(posedge clk_50);
        $display("Summary: %0d of %0d tests run, %0d failed, %0d byte errors, %0d other errors",
                 tests_run, n_tests, tests_failed, byte_errors, stray_events + tb_errors);
        if (tests_failed == 0 && byte_errors == 0 && stray_events == 0 && tb_errors == 0 &&
            tests_run == n_tests && n_tests > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Limit follows from the byte counts and lengths in the test list
    initial begin
        wait (wd_armed);
        repeat (wd_cycles) @(posedge clk_50);
        $display("The run timed out after %0d cycles before all tests finished", wd_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verilog.f */
src/r2f_pkg.sv
src/bank_ram.sv
src/bank_fill.sv
src/bank_gather.sv
src/byte_fifo.sv
src/fifo_drain.sv
src/r2f_seq.sv
src/r2f_top.sv
verif/r2f_checker.sv
verif/r2f_props.sv
verif/tb_r2f.sv
